/* hdl/pixPackPkg.sv */
`default_nettype none

package pixPackPkg;

	// pixel word, channel nibble and packed code
	typedef logic [15:0] rgb555T;
	typedef logic [3:0]  chanT;
	typedef logic [7:0]  packCodeT;

	// 5-bit hue index, top bit picks the nibble order
	typedef logic [4:0]  hueIdxT;

	// which channel is the saturated dominant one
	typedef logic [1:0]  domT;

	localparam domT DOM_NONE  = 2'd0;
	localparam domT DOM_RED   = 2'd1;
	localparam domT DOM_GREEN = 2'd2;
	localparam domT DOM_BLUE  = 2'd3;

	// general table escape into the low-bit table
	localparam hueIdxT HUE_ESCAPE = 5'h1F;

	// reserved codes
	localparam packCodeT TRANSP_CODE = 8'h00;
	localparam packCodeT DARK_CODE   = 8'h01;

	// bit 15 does not take part in keying
	localparam rgb555T KEY_MASK = 16'h7FFF;

endpackage

`default_nettype wire

/* hdl/rgb555Pack8.sv */
`default_nettype none

module rgb555Pack8 import pixPackPkg::*; (
	input  wire rgb555T pixIn,
	output packCodeT    packedCode
);

	chanT   chanR;
	chanT   chanG;
	chanT   chanB;
	chanT   intens;
	domT    dom;
	logic [2:0] shiftSel;

	chanT   addR;
	chanT   addG;
	chanT   addB;
	chanT   normR;
	chanT   normG;
	chanT   normB;

	hueIdxT hueGen;
	hueIdxT hueLow;
	hueIdxT hueRed;
	hueIdxT hueGreen;
	hueIdxT hueBlue;
	hueIdxT hue;

	always_comb begin
		chanR = pixIn[14:11];
		chanG = pixIn[9:6];
		chanB = pixIn[4:1];

		// green wins ties
		intens = chanG;
		dom = DOM_GREEN;
		if (chanR > intens) begin
			intens = chanR;
			dom = DOM_RED;
		end
		if (chanB > intens) begin
			intens = chanB;
			dom = DOM_BLUE;
		end

		case (intens)
			4'hF, 4'hE: shiftSel = 3'd0;
			4'hD: shiftSel = 3'd1;
			4'hC, 4'hB: shiftSel = 3'd2;
			4'hA, 4'h9, 4'h8: shiftSel = 3'd3;
			4'h7, 4'h6: shiftSel = 3'd4;
			4'h5, 4'h4: shiftSel = 3'd5;
			default: shiftSel = 3'd0;
		endcase

		// stretch mid intensities toward full scale
		case (shiftSel)
			3'd1: begin
				addR = {3'b000, chanR[3]};
				addG = {3'b000, chanG[3]};
				addB = {3'b000, chanB[3]};
			end
			3'd2: begin
				addR = {2'b00, chanR[3:2]};
				addG = {2'b00, chanG[3:2]};
				addB = {2'b00, chanB[3:2]};
			end
			3'd3: begin
				addR = {1'b0, chanR[3:1]};
				addG = {1'b0, chanG[3:1]};
				addB = {1'b0, chanB[3:1]};
			end
			3'd4: begin
				addR = chanR;
				addG = chanG;
				addB = chanB;
			end
			3'd5: begin
				addR = {chanR[2:0], 1'b0};
				addG = {chanG[2:0], 1'b0};
				addB = {chanB[2:0], 1'b0};
			end
			default: begin
				addR = '0;
				addG = '0;
				addB = '0;
			end
		endcase

		normR = chanR + addR;
		normG = chanG + addG;
		normB = chanB + addB;

		// general table on the upper two bits
		case ({normR[3:2], normG[3:2], normB[3:2]})
			6'h00: hueGen = 5'h00;
			6'h01: hueGen = 5'h01;
			6'h02: hueGen = 5'h01;
			6'h03: hueGen = 5'h01;
			6'h04: hueGen = 5'h02;
			6'h05: hueGen = 5'h03;
			6'h06: hueGen = 5'h01;
			6'h07: hueGen = 5'h01;
			6'h08: hueGen = 5'h02;
			6'h09: hueGen = 5'h02;
			6'h0A: hueGen = 5'h03;
			6'h0B: hueGen = 5'h13;
			6'h0C: hueGen = 5'h02;
			6'h0D: hueGen = 5'h02;
			6'h0E: hueGen = 5'h02;
			6'h0F: hueGen = 5'h03;
			6'h10: hueGen = 5'h04;
			6'h11: hueGen = 5'h05;
			6'h12: hueGen = 5'h01;
			6'h13: hueGen = 5'h01;
			6'h14: hueGen = 5'h06;
			6'h15: hueGen = 5'h1F;
			6'h16: hueGen = 5'h01;
			6'h17: hueGen = 5'h01;
			6'h18: hueGen = 5'h02;
			6'h19: hueGen = 5'h02;
			6'h1A: hueGen = 5'h03;
			6'h1B: hueGen = 5'h13;
			6'h1C: hueGen = 5'h02;
			6'h1D: hueGen = 5'h02;
			6'h1E: hueGen = 5'h0A;
			6'h1F: hueGen = 5'h03;
			6'h20: hueGen = 5'h04;
			6'h21: hueGen = 5'h04;
			6'h22: hueGen = 5'h05;
			6'h23: hueGen = 5'h01;
			6'h24: hueGen = 5'h04;
			6'h25: hueGen = 5'h04;
			6'h26: hueGen = 5'h05;
			6'h27: hueGen = 5'h09;
			6'h28: hueGen = 5'h06;
			6'h29: hueGen = 5'h06;
			6'h2A: hueGen = 5'h1F;
			6'h2B: hueGen = 5'h09;
			6'h2C: hueGen = 5'h12;
			6'h2D: hueGen = 5'h12;
			6'h2E: hueGen = 5'h0A;
			6'h2F: hueGen = 5'h0B;
			6'h30: hueGen = 5'h04;
			6'h31: hueGen = 5'h04;
			6'h32: hueGen = 5'h04;
			6'h33: hueGen = 5'h05;
			6'h34: hueGen = 5'h04;
			6'h35: hueGen = 5'h04;
			6'h36: hueGen = 5'h0C;
			6'h37: hueGen = 5'h05;
			6'h38: hueGen = 5'h11;
			6'h39: hueGen = 5'h11;
			6'h3A: hueGen = 5'h0C;
			6'h3B: hueGen = 5'h0D;
			6'h3C: hueGen = 5'h06;
			6'h3D: hueGen = 5'h06;
			6'h3E: hueGen = 5'h0E;
			default: hueGen = 5'h1F;
		endcase

		// low-bit table for near-neutral colours
		case ({normR[1:0], normG[1:0], normB[1:0]})
			6'h02, 6'h03, 6'h12, 6'h13, 6'h17: hueLow = 5'h07;
			6'h20, 6'h21, 6'h22, 6'h23, 6'h27: hueLow = 5'h07;
			6'h30, 6'h31, 6'h32, 6'h33: hueLow = 5'h07;
			6'h35, 6'h36, 6'h37: hueLow = 5'h07;
			6'h06, 6'h07, 6'h09, 6'h0A, 6'h0B: hueLow = 5'h0F;
			6'h0D, 6'h0E, 6'h0F: hueLow = 5'h0F;
			6'h1B, 6'h1E, 6'h1F: hueLow = 5'h0F;
			6'h08, 6'h0C, 6'h18, 6'h1C, 6'h1D: hueLow = 5'h08;
			6'h24, 6'h28, 6'h2C, 6'h2D: hueLow = 5'h08;
			6'h34, 6'h38, 6'h39, 6'h3C, 6'h3D: hueLow = 5'h08;
			default: hueLow = 5'h00;
		endcase

		// red dominant
		case ({normG[3:1], normB[3:1]})
			6'h20, 6'h21, 6'h22, 6'h23: hueRed = 5'h11;
			6'h28, 6'h29, 6'h2A, 6'h2B: hueRed = 5'h11;
			6'h24, 6'h25, 6'h2C, 6'h2D: hueRed = 5'h0C;
			6'h26, 6'h27, 6'h2E, 6'h2F: hueRed = 5'h0D;
			6'h30, 6'h31, 6'h32, 6'h33: hueRed = 5'h06;
			6'h38, 6'h39, 6'h3A, 6'h3B: hueRed = 5'h06;
			6'h34, 6'h35, 6'h3C, 6'h3D: hueRed = 5'h0E;
			6'h36, 6'h3F: hueRed = 5'h00;
			6'h37: hueRed = 5'h07;
			6'h3E: hueRed = 5'h08;
			default: hueRed = ({normG[3:1], normB[3:1]} & 6'h04) != 0 ? 5'h05 : 5'h04;
		endcase

		// green dominant
		case ({normR[3:1], normB[3:1]})
			6'h20, 6'h21, 6'h22, 6'h23: hueGreen = 5'h12;
			6'h28, 6'h29, 6'h2A, 6'h2B: hueGreen = 5'h12;
			6'h24, 6'h25, 6'h2C, 6'h2D: hueGreen = 5'h0A;
			6'h26, 6'h27, 6'h2E, 6'h2F: hueGreen = 5'h0B;
			6'h30, 6'h31, 6'h32, 6'h33: hueGreen = 5'h06;
			6'h38, 6'h39, 6'h3A, 6'h3B: hueGreen = 5'h06;
			6'h34, 6'h35, 6'h3C, 6'h3D: hueGreen = 5'h0E;
			6'h36, 6'h3F: hueGreen = 5'h00;
			6'h37: hueGreen = 5'h0F;
			6'h3E: hueGreen = 5'h08;
			default: hueGreen = ({normR[3:1], normB[3:1]} & 6'h04) != 0 ? 5'h03 : 5'h02;
		endcase

		// blue dominant
		case ({normR[3:1], normG[3:1]})
			6'h20, 6'h21, 6'h22, 6'h23: hueBlue = 5'h05;
			6'h28, 6'h29, 6'h2A, 6'h2B: hueBlue = 5'h05;
			6'h30, 6'h31, 6'h32, 6'h33: hueBlue = 5'h05;
			6'h38, 6'h39, 6'h3A, 6'h3B: hueBlue = 5'h05;
			6'h24, 6'h25, 6'h2C, 6'h2D: hueBlue = 5'h09;
			6'h26, 6'h27, 6'h2E, 6'h2F: hueBlue = 5'h0B;
			6'h34, 6'h35, 6'h3C, 6'h3D: hueBlue = 5'h0D;
			6'h36, 6'h3F: hueBlue = 5'h00;
			6'h37: hueBlue = 5'h0F;
			6'h3E: hueBlue = 5'h07;
			6'h04, 6'h05, 6'h0C, 6'h0D: hueBlue = 5'h13;
			6'h14, 6'h15, 6'h1C, 6'h1D: hueBlue = 5'h13;
			6'h06, 6'h07, 6'h0E, 6'h0F: hueBlue = 5'h03;
			6'h16, 6'h17, 6'h1E, 6'h1F: hueBlue = 5'h03;
			default: hueBlue = 5'h01;
		endcase

		// dominant tables only apply when that channel is saturated
		if (dom == DOM_RED && normR[3:1] != 3'b111) begin
			dom = DOM_NONE;
		end
		if (dom == DOM_GREEN && normG[3:1] != 3'b111) begin
			dom = DOM_NONE;
		end
		if (dom == DOM_BLUE && normB[3:1] != 3'b111) begin
			dom = DOM_NONE;
		end

		case (dom)
			DOM_RED: hue = hueRed;
			DOM_GREEN: hue = hueGreen;
			DOM_BLUE: hue = hueBlue;
			default: hue = hueGen;
		endcase

		if (hue == HUE_ESCAPE) begin
			hue = hueLow;
		end

		// very dark: snap to a primary or to gray
		if (intens[3:2] == 2'b00) begin
			if (intens[1:0] != 2'b00 && hue != 5'h00 && hue != 5'h07 &&
					hue[4:3] == 2'b00) begin
				case (dom)
					DOM_RED: hue = 5'h11;
					DOM_GREEN: hue = 5'h12;
					DOM_BLUE: hue = 5'h13;
					default: hue = hue;
				endcase
			end else begin
				hue = 5'h00;
			end
		end

		if (hue[4]) begin
			packedCode = {intens, hue[3:0]};
		end else begin
			packedCode = {hue[3:0], intens};
		end
	end

endmodule

`default_nettype wire

/* hdl/colorKeyMatch.sv */
`default_nettype none

module colorKeyMatch import pixPackPkg::*; (
	input  wire         clock,
	input  wire         arstN,
	input  wire         keyLoad,
	input  wire rgb555T keyIn,
	input  wire         keyEnable,
	input  wire rgb555T pixIn,
	output logic        keyHit
);

	rgb555T keyReg;

	// key register, zero out of reset
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			keyReg <= '0;
		end else if (keyLoad) begin
			keyReg <= keyIn;
		end
	end

	// compare only the colour bits
	always_comb begin
		keyHit = keyEnable && ((pixIn & KEY_MASK) == (keyReg & KEY_MASK));
	end

endmodule

`default_nettype wire

/* hdl/codeMerge.sv */
`default_nettype none

module codeMerge import pixPackPkg::*; (
	input  wire           clock,
	input  wire           arstN,
	input  wire           pixValid,
	input  wire           keyHit,
	input  wire packCodeT packedCode,
	output logic          codeValid,
	output packCodeT      codeOut
);

	packCodeT mergedCode;

	always_comb begin
		if (keyHit) begin
			mergedCode = TRANSP_CODE;
		end else if (packedCode == TRANSP_CODE) begin
			// opaque black must not look transparent
			mergedCode = DARK_CODE;
		end else begin
			mergedCode = packedCode;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			codeValid <= 1'b0;
			codeOut <= '0;
		end else begin
			codeValid <= pixValid;
			if (pixValid) begin
				codeOut <= mergedCode;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/pixPackTop.sv */
`default_nettype none

module pixPackTop import pixPackPkg::*; (
	input  wire           clock,
	input  wire           arstN,
	input  wire           pixValid,
	input  wire rgb555T   pixIn,
	input  wire           keyLoad,
	input  wire rgb555T   keyIn,
	input  wire           keyEnable,
	output wire           codeValid,
	output wire packCodeT codeOut
);

	wire packCodeT packedCode;
	wire           keyHit;

	rgb555Pack8 u_pack (
		.pixIn     (pixIn),
		.packedCode(packedCode)
	);

	colorKeyMatch u_key (
		.clock    (clock),
		.arstN    (arstN),
		.keyLoad  (keyLoad),
		.keyIn    (keyIn),
		.keyEnable(keyEnable),
		.pixIn    (pixIn),
		.keyHit   (keyHit)
	);

	codeMerge u_merge (
		.clock     (clock),
		.arstN     (arstN),
		.pixValid  (pixValid),
		.keyHit    (keyHit),
		.packedCode(packedCode),
		.codeValid (codeValid),
		.codeOut   (codeOut)
	);

endmodule

`default_nettype wire

/* sim/pixPack_chk.sv */
`default_nettype none

module pixPack_chk import pixPackPkg::*; (
	input wire           clock,
	input wire           arstN,
	input wire           pixValid,
	input wire           keyEnable,
	input wire           codeValid,
	input wire packCodeT codeOut
);

	int assertFails = 0;

	// one register stage from strobe in to strobe out
	validDelay: assert property (@(posedge clock) disable iff (!arstN)
			codeValid == $past(pixValid))
		else begin
			assertFails = assertFails + 1;
			$error("codeValid is not pixValid delayed by one cycle");
		end

	validInReset: assert property (@(posedge clock) !arstN |-> !codeValid)
		else begin
			assertFails = assertFails + 1;
			$error("codeValid high during reset");
		end

	// transparent only for a keyed pixel
	transpNeedsKey: assert property (@(posedge clock) disable iff (!arstN)
			(codeValid && codeOut == TRANSP_CODE) |-> $past(keyEnable))
		else begin
			assertFails = assertFails + 1;
			$error("transparent code without keyEnable");
		end

endmodule

bind pixPackTop pixPack_chk u_chk (
	.clock    (clock),
	.arstN    (arstN),
	.pixValid (pixValid),
	.keyEnable(keyEnable),
	.codeValid(codeValid),
	.codeOut  (codeOut)
);

`default_nettype wire

/* sim/pixPackTb.sv */
`default_nettype none

module pixPackTb import pixPackPkg::*; ();

	localparam int NUM_ENTRIES = 12;
	localparam int RAND_SEED = 25642;
	localparam int DRAIN_TIMEOUT = 20;
	localparam int MAX_GAP = 3;

	// pixels built from the RGB555 field layout
	localparam rgb555T PIX_WHITE = 16'h7BDE;
	localparam rgb555T PIX_RED   = 16'h7800;
	localparam rgb555T PIX_GREEN = 16'h03C0;
	localparam rgb555T PIX_BLUE  = 16'h001E;
	localparam rgb555T PIX_BLACK = 16'h0000;
	localparam rgb555T PIX_RED15 = 16'hF800;

	typedef struct packed {
		logic     keyEn;
		rgb555T   pix;
		packCodeT code;
	} stimT;

	logic     clock;
	logic     arstN;
	logic     pixValid;
	rgb555T   pixIn;
	logic     keyLoad;
	rgb555T   keyIn;
	logic     keyEnable;
	wire      codeValid;
	packCodeT codeOut;

	stimT     stimTable [0:NUM_ENTRIES-1];
	packCodeT expQueue [$];
	packCodeT expCode;
	logic     prevPixValid;
	int       seedVal;

	pixPackTop u_dut (
		.clock    (clock),
		.arstN    (arstN),
		.pixValid (pixValid),
		.pixIn    (pixIn),
		.keyLoad  (keyLoad),
		.keyIn    (keyIn),
		.keyEnable(keyEnable),
		.codeValid(codeValid),
		.codeOut  (codeOut)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAIL t=%0t: %s, got %0h expected %0h", $time, what, actual, expected);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abortRun(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("TB FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic fillTable();
		// primaries, white and black with keying off
		stimTable[0]  = '{1'b0, PIX_WHITE, 8'h0F};
		stimTable[1]  = '{1'b0, PIX_RED,   8'h4F};
		stimTable[2]  = '{1'b0, PIX_GREEN, 8'h2F};
		stimTable[3]  = '{1'b0, PIX_BLUE,  8'h1F};
		stimTable[4]  = '{1'b0, PIX_BLACK, DARK_CODE};
		// key holds pure red from here on
		stimTable[5]  = '{1'b1, PIX_RED,   TRANSP_CODE};
		stimTable[6]  = '{1'b1, PIX_WHITE, 8'h0F};
		stimTable[7]  = '{1'b1, PIX_RED15, TRANSP_CODE};
		stimTable[8]  = '{1'b0, PIX_RED15, 8'h4F};
		stimTable[9]  = '{1'b1, PIX_BLACK, DARK_CODE};
		stimTable[10] = '{1'b1, PIX_GREEN, 8'h2F};
		stimTable[11] = '{1'b0, PIX_RED,   8'h4F};
	endtask

	task automatic loadKey(input rgb555T key);
		@(posedge clock);
		keyLoad <= 1'b1;
		keyIn <= key;
		@(posedge clock);
		keyLoad <= 1'b0;
	endtask

	task automatic runTable(input logic withGaps);
		int gap;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			@(posedge clock);
			pixValid <= 1'b1;
			pixIn <= stimTable[i].pix;
			keyEnable <= stimTable[i].keyEn;
			expQueue.push_back(stimTable[i].code);
			gap = withGaps ? $urandom_range(MAX_GAP, 0) : 0;
			repeat (gap) begin
				@(posedge clock);
				pixValid <= 1'b0;
			end
		end
		@(posedge clock);
		pixValid <= 1'b0;
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (expQueue.size() != 0 && waited < DRAIN_TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (expQueue.size() != 0) begin
			abortRun("timeout waiting for codeValid on outstanding pixels");
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clock) begin
		if (arstN) begin
			checkEq(u_dut.u_chk.assertFails, 0, "assertion failures");
			checkEq(codeValid, prevPixValid, "codeValid one cycle after pixValid");
			if (codeValid) begin
				if (expQueue.size() == 0) begin
					abortRun("codeValid raised with no pixel outstanding");
				end else begin
					expCode = expQueue.pop_front();
					checkEq(codeOut, expCode, "codeOut");
				end
			end
		end
		prevPixValid = pixValid;
	end

	initial begin
		seedVal = $urandom(RAND_SEED);
		arstN = 1'b0;
		pixValid = 1'b0;
		pixIn = '0;
		keyLoad = 1'b0;
		keyIn = '0;
		keyEnable = 1'b0;
		prevPixValid = 1'b0;
		fillTable();

		repeat (16) @(posedge clock);
		arstN <= 1'b1;

		// idle outputs before the first pixel
		repeat (4) begin
			@(negedge clock);
			checkEq(codeValid, 1'b0, "codeValid after reset");
			checkEq(codeOut, 8'h00, "codeOut after reset");
		end

		loadKey(PIX_RED);
		runTable(1'b1);
		waitDrain();
		// second pass back to back
		runTable(1'b0);
		waitDrain();
		repeat (2) @(negedge clock);

		if (u_dut.u_chk.assertFails == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("ERROR: %0d assertion failures", u_dut.u_chk.assertFails);
			$display("TB FAILED");
			$fatal(1, "run ended with errors");
		end
	end

endmodule

`default_nettype wire

/* build.f */
hdl/pixPackPkg.sv
hdl/rgb555Pack8.sv
hdl/colorKeyMatch.sv
hdl/codeMerge.sv
hdl/pixPackTop.sv
sim/pixPack_chk.sv
sim/pixPackTb.sv

/* Bender.yml */
package:
  name: pix_pack

sources:
  - hdl/pixPackPkg.sv
  - hdl/rgb555Pack8.sv
  - hdl/colorKeyMatch.sv
  - hdl/codeMerge.sv
  - hdl/pixPackTop.sv
  - target: simulation
    files:
      - sim/pixPack_chk.sv
      - sim/pixPackTb.sv
